/* design/sdramPkg.sv */
// Shared geometry, command codes, mode word and types for the AHB-Lite SDRAM controller
// Pulled into each module by a wildcard import in the module header
package sdramPkg;

    // x16 part, 4 banks
    localparam int rowBits  = 13;
    localparam int colBits  = 10;
    localparam int bankBits = 2;
    localparam int dqBits   = 16;
    localparam int dmBits   = 2;
    localparam int addrBits = 13;

    // {CKE, CSn, RASn, CASn, WEn}
    typedef enum logic [4:0] {
        NopNoCke     = 5'b00111, // Power-up hold, CKE low
        Nop          = 5'b10111,
        PrechargeAll = 5'b10010, // A10 set
        AutoRefresh  = 5'b10001,
        LoadMode     = 5'b10000,
        Active       = 5'b10011,
        Read         = 5'b10101, // A10 set, auto-precharge
        Write        = 5'b10100
    } sdramCmd_t;

    // CAS 2, sequential, BL 2
    localparam logic [addrBits-1:0] modeWord = {6'b000000, 3'b010, 1'b0, 3'b001};

    localparam int allBanksBit = 10; // All banks / auto-precharge

    typedef enum logic [4:0] {
        Idle,
        Init0NoCke, Init1NoCke, Init2Cke, Init3Nop, Init4PrechargeAll,
        Init5Nop, Init6PreRef, Init7AutoRef, Init8Nop, Init9Lmr, Init10Nop,
        Read0Act, Read1Nop, Read2Read, Read3Nop, Read4Rd0, Read5Rd1, Read6Nop,
        Write0Act, Write1Nop, Write2Wr0, Write3Wr1, Write4Nop,
        Aref0, Aref1
    } seqState_t;

    // AHB byte address split into SDRAM fields
    typedef struct packed {
        logic [5:0]          unused;  // Above the 64 MB space
        logic [bankBits-1:0] bank;
        logic [rowBits-1:0]  row;
        logic [colBits-2:0]  colHigh; // Column LSB always zero
        logic [1:0]          byteNum;
    } ahbAddrFields_t;

    typedef union packed {
        logic [31:0]    flat;
        ahbAddrFields_t fields;
    } ahbAddr_t;

    typedef enum logic [2:0] {
        SizeByte = 3'b000,
        SizeHalf = 3'b001,
        SizeWord = 3'b010
    } ahbSize_t;

    localparam logic [1:0] htransIdle = 2'b00;

endpackage

/* design/ahbCapture.sv */
// AHB-Lite address phase capture for the SDRAM controller
// Flags a live request and holds address, size and write data for the sequencer
`timescale 1ns/1ns

module ahbCapture import sdramPkg::*; (
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        HSEL,
    input  logic        HREADY,
    input  logic [1:0]  HTRANS,
    input  logic        HWRITE,
    input  ahbSize_t    HSIZE,
    input  logic [31:0] HADDR,
    input  logic [31:0] HWDATA,
    input  logic        accept,    // Sequencer can take a request
    input  logic        loadWdata, // Data phase of an accepted write
    output logic        needAction,
    output logic        reqWrite,
    output ahbAddr_t    addr,
    output ahbSize_t    size,
    output logic [31:0] wdata
);

    // Valid address phase aimed at us
    assign needAction = HSEL && HREADY && (HTRANS != htransIdle);

    // Direction decided live, same cycle as the request
    assign reqWrite = HWRITE;

    // Transfer attributes, frozen once the sequencer leaves Idle
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            addr.flat <= '0;
            size      <= SizeByte;
        end else if (accept && HSEL) begin
            addr.flat <= HADDR;
            size      <= HSIZE;
        end
    end

    // Write data arrives one cycle after the address phase
    always_ff @(posedge HCLK) begin
        if (loadWdata) begin
            wdata <= HWDATA; // Held through both write beats
        end
    end

endmodule

/* design/sdramSequencer.sv */
// SDRAM command sequencer: power-up init, single read/write bursts and auto-refresh
// State drives the pin stage; ready is the AHB HREADYOUT
// Zero-valued delay parameters skip their wait states
`timescale 1ns/1ns

module sdramSequencer import sdramPkg::*; #(
    parameter int unsigned delayNoCke      = 20,  // CKE low hold after reset
    parameter int unsigned delayRef        = 390, // Refresh interval
    parameter int unsigned delayRp         = 0,
    parameter int unsigned delayRfc        = 2,
    parameter int unsigned delayMrd        = 0,
    parameter int unsigned delayRcd        = 0,
    parameter int unsigned delayCas        = 0,
    parameter int unsigned delayAfterRead  = 0,
    parameter int unsigned delayAfterWrite = 2,
    parameter int unsigned initRefCount    = 2
) (
    input  logic      HCLK,
    input  logic      HRESETn,
    input  logic      needAction,
    input  logic      reqWrite,
    output seqState_t state,
    output logic      ready,
    output logic      accept,
    output logic      loadWdata
);

    localparam int shortW  = 8;
    localparam int longMax = (delayRef > delayNoCke) ? delayRef : delayNoCke;
    localparam int longW   = $clog2(longMax + 2);
    localparam int repW    = $clog2(initRefCount + 2);

    seqState_t         nextState;
    logic [shortW-1:0] shortCnt;  // Per-command wait
    logic [longW-1:0]  longCnt;   // CKE hold, then refresh interval
    logic [repW-1:0]   repeatCnt; // Init refreshes left

    logic shortDone;
    logic longDone;
    logic repeatsDone;
    logic startState; // Idle or last init wait

    assign shortDone   = (shortCnt == '0);
    assign longDone    = (longCnt == '0); // Also means refresh due
    assign repeatsDone = (repeatCnt == '0);

    assign startState = (state == Idle) || (state == Init10Nop);
    assign ready      = (state == Idle);
    assign accept     = startState;
    assign loadWdata  = (state == Write0Act);

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state <= Init0NoCke;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (needAction) begin
                    nextState = reqWrite ? Write0Act : Read0Act;
                end else if (longDone) begin
                    nextState = Aref0;
                end
            end
            Init0NoCke:        nextState = Init1NoCke;
            Init1NoCke:        nextState = longDone ? Init2Cke : Init1NoCke;
            Init2Cke:          nextState = Init3Nop;
            Init3Nop:          nextState = Init4PrechargeAll;
            Init4PrechargeAll: nextState = (delayRp == 0) ? Init6PreRef : Init5Nop;
            Init5Nop:          nextState = shortDone ? Init6PreRef : Init5Nop;
            Init6PreRef:       nextState = Init7AutoRef;
            Init7AutoRef:      nextState = Init8Nop;
            Init8Nop: begin
                if (shortDone) begin
                    nextState = repeatsDone ? Init9Lmr : Init7AutoRef; // Next init refresh
                end
            end
            Init9Lmr:          nextState = Init10Nop;
            Init10Nop: begin
                if (shortDone) begin
                    if (!needAction) begin
                        nextState = Idle;
                    end else begin
                        nextState = reqWrite ? Write0Act : Read0Act; // Skip Idle
                    end
                end
            end

            Read0Act:  nextState = (delayRcd == 0) ? Read2Read : Read1Nop;
            Read1Nop:  nextState = shortDone ? Read2Read : Read1Nop;
            Read2Read: nextState = (delayCas == 0) ? Read4Rd0 : Read3Nop;
            Read3Nop:  nextState = shortDone ? Read4Rd0 : Read3Nop;
            Read4Rd0:  nextState = Read5Rd1;
            Read5Rd1: begin
                if (delayAfterRead != 0) begin
                    nextState = Read6Nop;
                end else begin
                    nextState = longDone ? Aref0 : Idle;
                end
            end
            Read6Nop: begin
                if (shortDone) begin
                    nextState = longDone ? Aref0 : Idle;
                end
            end

            Write0Act: nextState = (delayRcd == 0) ? Write2Wr0 : Write1Nop;
            Write1Nop: nextState = shortDone ? Write2Wr0 : Write1Nop;
            Write2Wr0: nextState = Write3Wr1;
            Write3Wr1: begin
                if (delayAfterWrite != 0) begin
                    nextState = Write4Nop;
                end else begin
                    nextState = longDone ? Aref0 : Idle;
                end
            end
            Write4Nop: begin
                if (shortDone) begin
                    nextState = longDone ? Aref0 : Idle;
                end
            end

            Aref0:   nextState = Aref1;
            Aref1:   nextState = shortDone ? Idle : Aref1;
            default: nextState = Idle;
        endcase
    end

    // Short wait, loaded by the command that starts it
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            shortCnt <= '0;
        end else begin
            case (state)
                Init4PrechargeAll: shortCnt <= shortW'(delayRp - 1);
                Init7AutoRef:      shortCnt <= shortW'(delayRfc); // delayRfc+1 waits
                Init9Lmr:          shortCnt <= shortW'(delayMrd);
                Read0Act:          shortCnt <= shortW'(delayRcd - 1);
                Read2Read:         shortCnt <= shortW'(delayCas - 1);
                Read5Rd1:          shortCnt <= shortW'(delayAfterRead - 1);
                Write0Act:         shortCnt <= shortW'(delayRcd - 1);
                Write3Wr1:         shortCnt <= shortW'(delayAfterWrite - 1);
                Aref0:             shortCnt <= shortW'(delayRfc);
                default: begin
                    if (!shortDone) begin
                        shortCnt <= shortCnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // Long counter and init refresh repeats
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            longCnt   <= '0;
            repeatCnt <= '0;
        end else begin
            case (state)
                Init0NoCke:          longCnt <= longW'(delayNoCke);
                Init7AutoRef, Aref0: longCnt <= longW'(delayRef); // Restart interval
                default: begin
                    if (!longDone) begin
                        longCnt <= longCnt - 1'b1;
                    end
                end
            endcase

            if (state == Init6PreRef) begin
                repeatCnt <= repW'(initRefCount);
            end else if (state == Init7AutoRef) begin
                repeatCnt <= repeatCnt - 1'b1;
            end
        end
    end

endmodule

/* design/sdramPins.sv */
// SDRAM pin stage: command, address, write data and byte masks per sequencer state
// Also gathers the two read beats into HRDATA
`timescale 1ns/1ns

module sdramPins import sdramPkg::*; (
    input  logic                HCLK,
    input  seqState_t           state,
    input  ahbAddr_t            addr,
    input  ahbSize_t            size,
    input  logic [31:0]         wdata,
    output logic                CKE,
    output logic                CSn,
    output logic                RASn,
    output logic                CASn,
    output logic                WEn,
    output logic [addrBits-1:0] ADDR,
    output logic [bankBits-1:0] BA,
    inout  wire  [dqBits-1:0]   DQ,
    output logic [dmBits-1:0]   DQM,
    output logic [31:0]         HRDATA
);

    sdramCmd_t           cmd;
    logic [addrBits-1:0] colAddr;  // Column with auto-precharge
    logic [dqBits-1:0]   dqOut;
    logic [dqBits-1:0]   rdLow;    // First read beat
    logic                driveDq;
    logic                highBeat; // Second write beat
    logic                laneHit;  // Target bytes sit in this beat

    assign colAddr = addrBits'({addr.fields.colHigh, 1'b0})
                   | (addrBits'(1) << allBanksBit);

    assign {CKE, CSn, RASn, CASn, WEn} = cmd;

    always_comb begin
        cmd  = Nop;
        ADDR = '0;
        BA   = '0;
        case (state)
            Init0NoCke, Init1NoCke: cmd = NopNoCke;
            Init4PrechargeAll: begin
                cmd               = PrechargeAll;
                ADDR[allBanksBit] = 1'b1;
            end
            Init7AutoRef, Aref0: cmd = AutoRefresh;
            Init9Lmr: begin
                cmd  = LoadMode;
                ADDR = modeWord; // BA stays zero
            end
            Read0Act, Write0Act: begin
                cmd  = Active;
                ADDR = addr.fields.row;
                BA   = addr.fields.bank;
            end
            Read2Read: begin
                cmd  = Read;
                ADDR = colAddr;
                BA   = addr.fields.bank;
            end
            Write2Wr0: begin
                cmd  = Write;
                ADDR = colAddr;
                BA   = addr.fields.bank;
            end
            default: ;
        endcase
    end

    // Low half first, then high half
    assign driveDq  = (state == Write2Wr0) || (state == Write3Wr1);
    assign highBeat = (state == Write3Wr1);
    assign dqOut    = highBeat ? wdata[31:16] : wdata[15:0];
    assign DQ       = driveDq ? dqOut : {dqBits{1'bz}};

    assign laneHit = (addr.fields.byteNum[1] == highBeat);

    // DQM high masks a byte lane
    always_comb begin
        DQM = '0;
        if (driveDq) begin
            case (size)
                SizeByte: DQM = laneHit ? (addr.fields.byteNum[0] ? 2'b01 : 2'b10) : 2'b11;
                SizeHalf: DQM = laneHit ? 2'b00 : 2'b11;
                default:  DQM = 2'b00; // Word, both beats
            endcase
        end
    end

    // Read beats sampled at end of their cycles
    always_ff @(posedge HCLK) begin
        if (state == Read4Rd0) begin
            rdLow <= DQ;
        end
        if (state == Read5Rd1) begin
            HRDATA <= {DQ, rdLow}; // Valid when HREADYOUT rises
        end
    end

endmodule

/* design/ahbSdramTop.sv */
// AHB-Lite slave for one x16 SDRAM
// Capture, sequencer and pin stages; timing parameters set here and passed down
`timescale 1ns/1ns

module ahbSdramTop import sdramPkg::*; #(
    parameter int unsigned delayNoCke      = 20,
    parameter int unsigned delayRef        = 390,
    parameter int unsigned delayRp         = 0,
    parameter int unsigned delayRfc        = 2,
    parameter int unsigned delayMrd        = 0,
    parameter int unsigned delayRcd        = 0,
    parameter int unsigned delayCas        = 0,
    parameter int unsigned delayAfterRead  = 0,
    parameter int unsigned delayAfterWrite = 2,
    parameter int unsigned initRefCount    = 2
) (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  logic [31:0]         HADDR,
    input  logic                HSEL,
    input  ahbSize_t            HSIZE,
    input  logic [1:0]          HTRANS,
    input  logic [31:0]         HWDATA,
    input  logic                HWRITE,
    input  logic                HREADY,
    output logic [31:0]         HRDATA,
    output logic                HREADYOUT,
    output logic                HRESP,
    output logic                CKE,
    output logic                CSn,
    output logic                RASn,
    output logic                CASn,
    output logic                WEn,
    output logic [addrBits-1:0] ADDR,
    output logic [bankBits-1:0] BA,
    inout  wire  [dqBits-1:0]   DQ,
    output logic [dmBits-1:0]   DQM
);

    logic        needAction;
    logic        reqWrite;
    logic        accept;
    logic        loadWdata;
    seqState_t   state;
    ahbAddr_t    addr;
    ahbSize_t    size;
    logic [31:0] wdata;

    assign HRESP = 1'b0; // Always OKAY

    ahbCapture capture (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HSEL       (HSEL),
        .HREADY     (HREADY),
        .HTRANS     (HTRANS),
        .HWRITE     (HWRITE),
        .HSIZE      (HSIZE),
        .HADDR      (HADDR),
        .HWDATA     (HWDATA),
        .accept     (accept),
        .loadWdata  (loadWdata),
        .needAction (needAction),
        .reqWrite   (reqWrite),
        .addr       (addr),
        .size       (size),
        .wdata      (wdata)
    );

    sdramSequencer #(
        .delayNoCke      (delayNoCke),
        .delayRef        (delayRef),
        .delayRp         (delayRp),
        .delayRfc        (delayRfc),
        .delayMrd        (delayMrd),
        .delayRcd        (delayRcd),
        .delayCas        (delayCas),
        .delayAfterRead  (delayAfterRead),
        .delayAfterWrite (delayAfterWrite),
        .initRefCount    (initRefCount)
    ) sequencer (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .needAction (needAction),
        .reqWrite   (reqWrite),
        .state      (state),
        .ready      (HREADYOUT), // High only in Idle
        .accept     (accept),
        .loadWdata  (loadWdata)
    );

    sdramPins pins (
        .HCLK   (HCLK),
        .state  (state),
        .addr   (addr),
        .size   (size),
        .wdata  (wdata),
        .CKE    (CKE),
        .CSn    (CSn),
        .RASn   (RASn),
        .CASn   (CASn),
        .WEn    (WEn),
        .ADDR   (ADDR),
        .BA     (BA),
        .DQ     (DQ),
        .DQM    (DQM),
        .HRDATA (HRDATA)
    );

endmodule

/* tb/sdramModel.sv */
// Behavioral x16 SDRAM for the controller testbench
// Checks the power-up command order, stores masked writes, answers BL2 reads after casLat
`timescale 1ns/1ns

module sdramModel import sdramPkg::*; #(
    parameter int casLat       = 0,
    parameter int initRefCount = 2
) (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  logic                CKE,
    input  logic                CSn,
    input  logic                RASn,
    input  logic                CASn,
    input  logic                WEn,
    input  logic [addrBits-1:0] ADDR,
    input  logic [bankBits-1:0] BA,
    inout  wire  [dqBits-1:0]   DQ,
    input  logic [dmBits-1:0]   DQM,
    output logic                initDone,
    output logic                seqError,   // Illegal command order seen
    output int                  refreshCount
);

    sdramCmd_t          cmd;
    logic [rowBits-1:0] openRow [4];
    logic [15:0]        mem [int];  // Key is {bank, row, column}
    int                 cmdKey;
    int                 rdKeyReg;
    int                 rdKeyCur;
    int                 wrKey;
    int                 rdAge;      // Cycles since READ, -1 when idle
    int                 curAge;
    int                 initRefs;
    logic               preSeen;
    logic               wrSecond;   // Second write beat due
    logic [15:0]        dqReg;
    logic               dqEn;

    assign cmd      = sdramCmd_t'({CKE, CSn, RASn, CASn, WEn});
    assign cmdKey   = int'({BA, openRow[BA], ADDR[colBits-1:0]});
    assign rdKeyCur = (cmd == Read) ? cmdKey : rdKeyReg;
    assign curAge   = (cmd == Read) ? 0 : rdAge;
    assign DQ       = dqEn ? dqReg : {dqBits{1'bz}};

    function automatic logic [15:0] readWord(input int key);
        return mem.exists(key) ? mem[key] : 16'h0000; // Unwritten reads as zero
    endfunction

    task automatic writeMasked(input int key, input logic [15:0] data, input logic [1:0] mask);
        logic [15:0] word;
        word = readWord(key);
        if (!mask[0]) word[7:0] = data[7:0];
        if (!mask[1]) word[15:8] = data[15:8];
        mem[key] = word;
    endtask

    always @(posedge HCLK) begin
        if (!HRESETn) begin
            initDone     <= 1'b0;
            seqError     <= 1'b0;
            refreshCount <= 0;
            initRefs     <= 0;
            preSeen      <= 1'b0;
            wrSecond     <= 1'b0;
            rdAge        <= -1;
            dqEn         <= 1'b0;
        end else begin
            // Read beats, low word first
            if (curAge == casLat) begin
                dqReg <= readWord(rdKeyCur);
                dqEn  <= 1'b1;
            end else if (curAge == casLat + 1) begin
                dqReg <= readWord(rdKeyCur | 1);
            end else begin
                dqEn <= 1'b0;
            end
            rdAge <= (curAge >= 0 && curAge <= casLat) ? curAge + 1 : -1;

            if (wrSecond) writeMasked(wrKey | 1, DQ, DQM); // Sequential burst
            wrSecond <= 1'b0;

            case (cmd)
                PrechargeAll: begin
                    if (preSeen || initDone) seqError <= 1'b1;
                    preSeen <= 1'b1;
                end
                AutoRefresh: begin
                    refreshCount <= refreshCount + 1;
                    if (!initDone && !preSeen) seqError <= 1'b1;
                    if (!initDone) initRefs <= initRefs + 1;
                end
                LoadMode: begin
                    if (initDone || !preSeen || initRefs != initRefCount) seqError <= 1'b1;
                    if (ADDR != modeWord || BA != '0) seqError <= 1'b1; // Wrong mode
                    initDone <= 1'b1;
                end
                Active: begin
                    if (!initDone) seqError <= 1'b1;
                    openRow[BA] <= ADDR;
                end
                Read: begin
                    if (!initDone || !ADDR[allBanksBit]) seqError <= 1'b1;
                    rdKeyReg <= cmdKey;
                end
                Write: begin
                    if (!initDone || !ADDR[allBanksBit]) seqError <= 1'b1;
                    writeMasked(cmdKey, DQ, DQM);
                    wrKey    <= cmdKey;
                    wrSecond <= 1'b1;
                end
                default: ; // NOP and CKE low
            endcase
        end
    end

endmodule

/* tb/sdramCmd_sva.sv */
// Bound checks on the SDRAM pins of the controller top level
// Command legality after init, refresh spacing, DQ drive and HRESP
`timescale 1ns/1ns

module sdramCmd_sva import sdramPkg::*; #(
    parameter int unsigned delayRef      = 390,
    parameter int unsigned transferBound = 16  // Longest transfer plus refresh wait
) (
    input logic      HCLK,
    input logic      HRESETn,
    input seqState_t state,
    input logic      CKE,
    input logic      CSn,
    input logic      RASn,
    input logic      CASn,
    input logic      WEn,
    input logic      dqDrive,
    input logic      HRESP
);

    sdramCmd_t   cmd;
    int unsigned sinceRef;
    logic        running; // Init finished

    assign cmd = sdramCmd_t'({CKE, CSn, RASn, CASn, WEn});

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            sinceRef <= 0;
            running  <= 1'b0;
        end else begin
            if (state == Idle) running <= 1'b1;
            sinceRef <= (cmd == AutoRefresh) ? 0 : sinceRef + 1;
        end
    end

    // No precharge-all or mode load once running
    legalCmd: assert property (@(posedge HCLK) disable iff (!HRESETn)
        running && CKE && !CSn |-> cmd inside {Nop, Active, Read, Write, AutoRefresh})
        else $error("illegal SDRAM command after init");

    refreshSpacing: assert property (@(posedge HCLK) disable iff (!HRESETn)
        running |-> sinceRef <= delayRef + transferBound)
        else $error("auto-refresh interval too long");

    // DQ enable only in the WRITE cycle and the beat after it
    dqOnlyWrite: assert property (@(posedge HCLK) disable iff (!HRESETn)
        dqDrive |-> (cmd == Write) || $past(cmd == Write))
        else $error("DQ driven outside a write burst");

    respOkay: assert property (@(posedge HCLK) HRESP == 1'b0)
        else $error("HRESP not OKAY");

endmodule

/* tb/tbTop.sv */
// Testbench for the AHB-Lite SDRAM controller with a behavioral SDRAM
// Random word, halfword and byte traffic checked against a byte-wide reference memory
`timescale 1ns/1ns

module tbTop import sdramPkg::*;;

    localparam int unsigned delayRef     = 390;
    localparam int unsigned delayCas     = 0;
    localparam int unsigned initRefCount = 2;
    localparam int          readyTimeout = 1000; // Cycles including init
    localparam int          poolSize     = 8;

    logic        HCLK;
    logic        HRESETn;
    logic [31:0] HADDR;
    logic        HSEL;
    ahbSize_t    HSIZE;
    logic [1:0]  HTRANS;
    logic [31:0] HWDATA;
    logic        HWRITE;
    logic        HREADY;
    logic [31:0] HRDATA;
    logic        HREADYOUT;
    logic        HRESP;
    logic        CKE;
    logic        CSn;
    logic        RASn;
    logic        CASn;
    logic        WEn;
    logic [addrBits-1:0] ADDR;
    logic [bankBits-1:0] BA;
    wire  [dqBits-1:0]   DQ;
    logic [dmBits-1:0]   DQM;
    logic initDone;
    logic seqError;
    int   refreshCount;

    logic [7:0]  refMem [int]; // Byte address to byte
    logic [31:0] expQ [$];
    logic [31:0] actQ [$];
    logic [31:0] pool [poolSize];

    assign HREADY = HREADYOUT; // Single slave on the bus

    ahbSdramTop #(
        .delayRef     (delayRef),
        .delayCas     (delayCas),
        .initRefCount (initRefCount)
    ) dut (.*);

    sdramModel #(.casLat(delayCas), .initRefCount(initRefCount)) sdram (.*);

    bind ahbSdramTop sdramCmd_sva #(.delayRef(delayRef)) cmdChecks (
        .HCLK(HCLK), .HRESETn(HRESETn), .state(state), .CKE(CKE), .CSn(CSn),
        .RASn(RASn), .CASn(CASn), .WEn(WEn), .dqDrive(pins.driveDq), .HRESP(HRESP)
    );

    initial begin
        HCLK = 1'b0;
        forever #2 HCLK = ~HCLK;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkEqual(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // Applies a write to the reference bytes and returns the aligned word
    function automatic logic [31:0] expectRead(input logic [31:0] a, input logic write,
                                               input ahbSize_t s, input logic [31:0] d);
        int          base;
        int          first;
        int          count;
        logic [31:0] word;
        base = int'(a & 32'h03FF_FFFC);
        case (s)
            SizeByte: begin
                first = int'(a[1:0]);
                count = 1;
            end
            SizeHalf: begin
                first = int'({a[1], 1'b0});
                count = 2;
            end
            default: begin
                first = 0;
                count = 4;
            end
        endcase
        if (write) begin
            for (int i = first; i < first + count; i++) refMem[base + i] = d[8*i +: 8];
        end
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = refMem.exists(base + i) ? refMem[base + i] : 8'h00; // Little-endian
        end
        return word;
    endfunction

    // Edge where HREADYOUT was high, sampled before the DUT updates
    task automatic waitReady(input string what);
        int cycles;
        cycles = 0;
        @(posedge HCLK);
        while (HREADYOUT !== 1'b1) begin
            cycles++;
            if (cycles > readyTimeout) failRun({"Timed out waiting for HREADYOUT in ", what});
            @(posedge HCLK);
        end
    endtask

    task automatic busTransfer(input logic write, input logic [31:0] a, input ahbSize_t s,
                               input logic [31:0] d);
        @(posedge HCLK);
        HSEL   <= 1'b1;
        HTRANS <= 2'b10; // NONSEQ
        HADDR  <= a;
        HWRITE <= write;
        HSIZE  <= s;
        waitReady("address phase");
        HSEL   <= 1'b0;
        HTRANS <= htransIdle;
        HWDATA <= d;     // Data phase
        waitReady("data phase");
        if (write) begin
            void'(expectRead(a, 1'b1, s, d));
        end else begin
            expQ.push_back(expectRead(a, 1'b0, s, 32'h0));
            actQ.push_back(HRDATA);
        end
    endtask

    // Compare process
    initial begin
        logic [31:0] got;
        logic [31:0] exp;
        forever begin
            @(posedge HCLK);
            if (seqError) failRun("SDRAM model saw an illegal command sequence");
            if (actQ.size() > 0) begin
                got = actQ.pop_front();
                exp = expQ.pop_front();
                checkEqual("HRDATA", got, exp);
            end
        end
    end

    initial begin
        logic [31:0] a;
        ahbSize_t    s;
        int          refBefore;
        int          drain;
        void'($urandom(32'h1bdc));
        HRESETn = 1'b0;
        HADDR   = '0;
        HSEL    = 1'b0;
        HSIZE   = SizeWord;
        HTRANS  = htransIdle;
        HWDATA  = '0;
        HWRITE  = 1'b0;
        repeat (8) @(posedge HCLK);
        HRESETn <= 1'b1;
        @(posedge HCLK);
        checkEqual("HREADYOUT", 32'(HREADYOUT), 32'h0);
        checkEqual("CKE", 32'(CKE), 32'h0);
        waitReady("power-up init");
        checkEqual("initDone", 32'(initDone), 32'h1);

        // Full words written then read back
        for (int i = 0; i < poolSize; i++) begin
            pool[i] = $urandom & 32'h03FF_FFFC;
            busTransfer(1'b1, pool[i], SizeWord, $urandom);
        end
        for (int i = 0; i < poolSize; i++) busTransfer(1'b0, pool[i], SizeWord, 32'h0);

        // Each narrow write followed by a word read
        for (int i = 0; i < 24; i++) begin
            s = ($urandom % 2 == 0) ? SizeByte : SizeHalf;
            a = pool[$urandom % poolSize] | ($urandom & 32'h3);
            if (s == SizeHalf) a[0] = 1'b0;
            busTransfer(1'b1, a, s, $urandom);
            busTransfer(1'b0, a & 32'hFFFF_FFFC, SizeWord, 32'h0);
        end

        // Narrow reads still return the whole word
        for (int i = 0; i < 12; i++) begin
            s = ahbSize_t'($urandom % 3);
            busTransfer(1'b0, pool[$urandom % poolSize] | ($urandom & 32'h2), s, 32'h0);
        end

        // Refresh must keep running through a long idle stretch
        refBefore = refreshCount;
        repeat (3 * delayRef) @(posedge HCLK);
        checkEqual("refreshes in idle", 32'(refreshCount - refBefore >= 2), 32'h1);
        for (int i = 0; i < poolSize; i++) busTransfer(1'b0, pool[i], SizeWord, 32'h0);

        drain = 0;
        while (actQ.size() > 0) begin
            @(posedge HCLK);
            drain++;
            if (drain > 10) failRun("Read results were never compared");
        end
        @(posedge HCLK);
        $display("Everything OK");
        $finish;
    end

endmodule

/* tb.f */
design/sdramPkg.sv
design/ahbCapture.sv
design/sdramSequencer.sv
design/sdramPins.sv
design/ahbSdramTop.sv
tb/sdramModel.sv
tb/sdramCmd_sva.sv
tb/tbTop.sv

/* Makefile */
# Verilator build and run of the AHB-Lite SDRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tbTop
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)
